// ==== Bender.yml ====
package:
  name: audio_frame

sources:
  - common/storage_pkg.sv
  - common/sample_pkg.sv
  - src/sd_block_reader.sv
  - src/byte_fifo.sv
  - src/sample_pacer.sv
  - src/audio_pwm.sv
  - src/framing/sample_buffer.sv
  - src/framing/window_streamer.sv
  - src/audio_frame_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/audio_frame_tb.sv

// ==== audio_frame.f ====
+incdir+verification
common/storage_pkg.sv
common/sample_pkg.sv
src/sd_block_reader.sv
src/byte_fifo.sv
src/sample_pacer.sv
src/audio_pwm.sv
src/framing/sample_buffer.sv
src/framing/window_streamer.sv
src/audio_frame_top.sv
verification/audio_frame_tb.sv

// ==== common/sample_pkg.sv ====
package sample_pkg;

    ////////////////////
    // ring buffer and window sizes

    localparam int BUF_DEPTH  = 2048;
    localparam int WINDOW_LEN = 1024;
    // frames start every half window
    localparam int WINDOW_HOP = 512;

    ////////////////////
    // sample types

    // unsigned byte as read from the card
    typedef logic [7:0] sample_t;
    // signed byte as sent to the transform core
    typedef logic signed [7:0] frame_sample_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;

    // one ring buffer write from the pacer
    typedef struct packed {
        logic      strobe;
        buf_addr_t addr;
        sample_t   data;
    } buf_write_t;

    // one beat of the outgoing frame stream
    typedef struct packed {
        frame_sample_t data;
        logic          last;
    } frame_beat_t;

    // window streamer FSM
    typedef enum logic [1:0] {
        win_idle,
        win_read_request,
        win_read_wait,
        win_present
    } window_state_t;

endpackage

// ==== common/storage_pkg.sv ====
package storage_pkg;

    ////////////////////
    // SD card side

    // card byte address, advanced one block at a time
    typedef logic [31:0] sd_addr_t;
    typedef logic [7:0] sd_byte_t;

    localparam int SD_BLOCK_BYTES = 512;

    // counts bytes inside one block
    typedef logic [$clog2(SD_BLOCK_BYTES)-1:0] sd_block_count_t;

endpackage

// ==== src/audio_frame_top.sv ====
module audio_frame_top
    import storage_pkg::*;
    import sample_pkg::*;
#(
    parameter int SAMPLE_DIVIDER = 3125,
    parameter int FIFO_LOG_DEPTH = 9
)
(
    input  logic        clock,
    input  logic        reset,
    input  sd_byte_t    sd_data,
    input  logic        sd_read_available,
    output logic        sd_rd,
    output sd_addr_t    sd_addr,
    output logic        aud_pwm,
    output logic        frame_valid,
    output frame_beat_t frame,
    input  logic        frame_ready
);

    ////////////////////
    // card to FIFO

    logic       push;
    sd_byte_t   push_data;
    logic       fifo_empty;
    logic       pop;
    sd_byte_t   fifo_dout;

    // pacer to buffer, PWM and streamer
    buf_write_t sample_write;

    // streamer to buffer read port
    logic       read_request;
    buf_addr_t  read_addr;
    logic       read_grant;
    logic       read_valid;
    sample_t    read_data;

    sd_block_reader i_sd_block_reader (
        .clock             (clock),
        .reset             (reset),
        .sd_data           (sd_data),
        .sd_read_available (sd_read_available),
        .fifo_empty        (fifo_empty),
        .sd_rd             (sd_rd),
        .sd_addr           (sd_addr),
        .push              (push),
        .push_data         (push_data)
    );

    // overflow is not reported, a push into a full FIFO is simply lost
    byte_fifo #(
        .LOG_DEPTH (FIFO_LOG_DEPTH)
    ) i_byte_fifo (
        .clock (clock),
        .reset (reset),
        .push  (push),
        .din   (push_data),
        .pop   (pop),
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  ()
    );

    ////////////////////
    // sample rate side

    sample_pacer #(
        .SAMPLE_DIVIDER (SAMPLE_DIVIDER)
    ) i_sample_pacer (
        .clock        (clock),
        .reset        (reset),
        .fifo_empty   (fifo_empty),
        .fifo_dout    (fifo_dout),
        .pop          (pop),
        .sample_write (sample_write)
    );

    audio_pwm i_audio_pwm (
        .clock        (clock),
        .reset        (reset),
        .sample_write (sample_write),
        .aud_pwm      (aud_pwm)
    );

    ////////////////////
    // framing

    sample_buffer i_sample_buffer (
        .clock        (clock),
        .sample_write (sample_write),
        .read_request (read_request),
        .read_addr    (read_addr),
        .read_grant   (read_grant),
        .read_valid   (read_valid),
        .read_data    (read_data)
    );

    window_streamer i_window_streamer (
        .clock        (clock),
        .reset        (reset),
        .sample_write (sample_write),
        .read_grant   (read_grant),
        .read_valid   (read_valid),
        .read_data    (read_data),
        .read_request (read_request),
        .read_addr    (read_addr),
        .frame_valid  (frame_valid),
        .frame        (frame),
        .frame_ready  (frame_ready)
    );

endmodule

// ==== src/audio_pwm.sv ====
module audio_pwm
    import sample_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  buf_write_t sample_write,
    output logic       aud_pwm
);

    // sample currently being played
    sample_t    level;
    // free running ramp, one PWM period per wrap
    logic [7:0] ramp;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            level   <= '0;
            ramp    <= '0;
            aud_pwm <= 1'b0;
        end
        else
        begin
            ramp <= ramp + 1'b1;
            if (sample_write.strobe)
            begin
                level <= sample_write.data;
            end
            // high for level cycles out of every 256
            aud_pwm <= (ramp < level);
        end
    end

endmodule

// ==== src/byte_fifo.sv ====
module byte_fifo
    import storage_pkg::*;
#(
    parameter int LOG_DEPTH = 9
)
(
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  sd_byte_t din,
    input  logic     pop,
    output sd_byte_t dout,
    output logic     empty,
    output logic     full
);

    localparam int DEPTH = 1 << LOG_DEPTH;

    sd_byte_t             mem [DEPTH];
    logic [LOG_DEPTH-1:0] wr_ptr;
    logic [LOG_DEPTH-1:0] rd_ptr;
    // one extra bit so a full FIFO can be told from an empty one
    logic [LOG_DEPTH:0]   count;
    logic                 do_push;
    logic                 do_pop;

    // a push when full or a pop when empty is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (LOG_DEPTH + 1)'(DEPTH));

    ////////////////////
    // storage and read port

    always_ff @(posedge clock)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
        // dout is valid the cycle after the pop
        if (do_pop)
        begin
            dout <= mem[rd_ptr];
        end
    end

    ////////////////////
    // pointers and occupancy

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/framing/sample_buffer.sv ====
module sample_buffer
    import sample_pkg::*;
(
    input  logic       clock,
    input  buf_write_t sample_write,
    input  logic       read_request,
    input  buf_addr_t  read_addr,
    output logic       read_grant,
    output logic       read_valid,
    output sample_t    read_data
);

    sample_t   ram [BUF_DEPTH];
    // single port shared by the writer and the reader
    buf_addr_t ram_addr;

    ////////////////////
    // arbiter

    // the writer always wins, the reader gets any free cycle
    assign read_grant = read_request && !sample_write.strobe;
    assign ram_addr   = sample_write.strobe ? sample_write.addr : read_addr;

    ////////////////////
    // RAM port

    always_ff @(posedge clock)
    begin
        if (sample_write.strobe)
        begin
            ram[ram_addr] <= sample_write.data;
        end
        else if (read_grant)
        begin
            read_data <= ram[ram_addr];
        end
    end

    // data comes back one cycle after the grant
    always_ff @(posedge clock)
    begin
        read_valid <= read_grant;
    end

endmodule

// ==== src/framing/window_streamer.sv ====
module window_streamer
    import sample_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  buf_write_t  sample_write,
    input  logic        read_grant,
    input  logic        read_valid,
    input  sample_t     read_data,
    output logic        read_request,
    output buf_addr_t   read_addr,
    output logic        frame_valid,
    output frame_beat_t frame,
    input  logic        frame_ready
);

    localparam int HOP_WIDTH  = $clog2(WINDOW_HOP);
    localparam int BEAT_WIDTH = $clog2(WINDOW_LEN);

    window_state_t         state;
    // writes since the last hop boundary
    logic [HOP_WIDTH-1:0]  hop_count;
    // set once the first half window is in the buffer
    logic                  primed;
    logic                  trigger;
    buf_addr_t             trigger_addr;
    // one held window start
    logic                  pending;
    buf_addr_t             pending_addr;
    logic                  take_pending;
    logic [BEAT_WIDTH-1:0] beat_count;

    ////////////////////
    // window trigger

    // fires on the write that completes a hop, from the second hop on
    assign trigger = sample_write.strobe && primed &&
                     (hop_count == HOP_WIDTH'(WINDOW_HOP - 1));
    // oldest of the last WINDOW_LEN samples
    assign trigger_addr = sample_write.addr - buf_addr_t'(WINDOW_LEN - 1);
    assign take_pending = (state == win_idle) && pending;

    assign read_request = (state == win_read_request);
    assign frame_valid  = (state == win_present);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            hop_count <= '0;
            primed    <= 1'b0;
            pending   <= 1'b0;
        end
        else
        begin
            if (sample_write.strobe)
            begin
                hop_count <= hop_count + 1'b1;
                if (hop_count == HOP_WIDTH'(WINDOW_HOP - 1))
                begin
                    primed <= 1'b1;
                end
            end
            // a trigger with the slot already taken is dropped
            if (trigger && (!pending || take_pending))
            begin
                pending <= 1'b1;
            end
            else if (take_pending)
            begin
                pending <= 1'b0;
            end
        end
        // start address rides along with the pending flag
        if (trigger && (!pending || take_pending))
        begin
            pending_addr <= trigger_addr;
        end
    end

    ////////////////////
    // streaming FSM

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= win_idle;
        end
        else
        begin
            case (state)
                win_idle:
                begin
                    if (pending)
                    begin
                        read_addr  <= pending_addr;
                        beat_count <= '0;
                        state      <= win_read_request;
                    end
                end
                win_read_request:
                begin
                    // wait out any writer cycles
                    if (read_grant)
                    begin
                        state <= win_read_wait;
                    end
                end
                win_read_wait:
                begin
                    if (read_valid)
                    begin
                        // flip MSB for offset binary to signed
                        frame.data <= frame_sample_t'({~read_data[7], read_data[6:0]});
                        frame.last <= (beat_count == BEAT_WIDTH'(WINDOW_LEN - 1));
                        state      <= win_present;
                    end
                end
                win_present:
                begin
                    // beat held stable until the core takes it
                    if (frame_ready)
                    begin
                        // address wraps modulo BUF_DEPTH by width
                        read_addr  <= read_addr + 1'b1;
                        beat_count <= beat_count + 1'b1;
                        state      <= frame.last ? win_idle : win_read_request;
                    end
                end
                default:
                begin
                    state <= win_idle;
                end
            endcase
        end
    end

endmodule

// ==== src/sample_pacer.sv ====
module sample_pacer
    import storage_pkg::*;
    import sample_pkg::*;
#(
    parameter int SAMPLE_DIVIDER = 3125
)
(
    input  logic       clock,
    input  logic       reset,
    input  logic       fifo_empty,
    input  sd_byte_t   fifo_dout,
    output logic       pop,
    output buf_write_t sample_write
);

    localparam int DIV_WIDTH = $clog2(SAMPLE_DIVIDER);

    logic [DIV_WIDTH-1:0] div_count;
    logic                 tick;
    // fifo dout holds the popped byte this cycle
    logic                 popped;
    // next ring buffer slot to fill
    buf_addr_t            write_addr;

    // one tick every SAMPLE_DIVIDER clocks
    assign tick = (div_count == DIV_WIDTH'(SAMPLE_DIVIDER - 1));
    // skip the tick when there is nothing to play
    assign pop  = tick && !fifo_empty;

    always_ff @(posedge clock)
    begin
        // address and data of the coming strobe
        if (popped)
        begin
            sample_write.addr <= write_addr;
            sample_write.data <= sample_t'(fifo_dout);
        end

        if (reset)
        begin
            div_count           <= '0;
            popped              <= 1'b0;
            sample_write.strobe <= 1'b0;
            write_addr          <= '0;
        end
        else
        begin
            if (tick)
            begin
                div_count <= '0;
            end
            else
            begin
                div_count <= div_count + 1'b1;
            end

            popped              <= pop;
            // strobe lands two cycles after the tick
            sample_write.strobe <= popped;
            if (popped)
            begin
                // wraps around the ring buffer by width
                write_addr <= write_addr + 1'b1;
            end
        end
    end

endmodule

// ==== src/sd_block_reader.sv ====
module sd_block_reader
    import storage_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  sd_byte_t sd_data,
    input  logic     sd_read_available,
    input  logic     fifo_empty,
    output logic     sd_rd,
    output sd_addr_t sd_addr,
    output logic     push,
    output sd_byte_t push_data
);

    // previous level of the byte strobe from the card
    logic            last_available;
    logic            byte_edge;
    // bytes pushed so far in the current block
    sd_block_count_t block_count;

    // new byte from the card on a rising edge
    assign byte_edge = sd_read_available && !last_available;

    always_ff @(posedge clock)
    begin
        // take the card byte on the strobe edge
        if (byte_edge)
        begin
            push_data <= sd_data;
        end

        if (reset)
        begin
            sd_rd          <= 1'b0;
            last_available <= 1'b0;
            push           <= 1'b0;
            block_count    <= '0;
            sd_addr        <= '0;
        end
        else
        begin
            // ask the card for data whenever the FIFO has drained
            sd_rd          <= fifo_empty;
            last_available <= sd_read_available;
            // push goes out the cycle after the byte is taken
            push           <= byte_edge;

            if (push)
            begin
                if (block_count == sd_block_count_t'(SD_BLOCK_BYTES - 1))
                begin
                    // block done, move on to the next one on the card
                    block_count <= '0;
                    sd_addr     <= sd_addr + sd_addr_t'(SD_BLOCK_BYTES);
                end
                else
                begin
                    block_count <= block_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verification/audio_frame_model.svh ====
`ifndef AUDIO_FRAME_MODEL_SVH
`define AUDIO_FRAME_MODEL_SVH

////////////////////
// reference model

// one full frame as the transform core should see it
typedef frame_beat_t window_t [WINDOW_LEN];

// window k covers samples k*hop up to k*hop + len - 1
function automatic window_t expected_window(input sample_t history[$], input int k);
    window_t beats;
    int      first;
    int      i;
    sample_t s;
    first = k * WINDOW_HOP;
    for (i = 0; i < WINDOW_LEN; i++)
    begin
        // missing history shows up as a data mismatch
        s = (first + i < history.size()) ? history[first + i] : 8'h00;
        // offset binary to two's complement
        beats[i].data = frame_sample_t'(s ^ 8'h80);
        beats[i].last = (i == WINDOW_LEN - 1);
    end
    return beats;
endfunction

////////////////////
// SD card model

// waits for sd_rd, then hands over one block, one strobe per byte
task automatic supply_block(input bit fixed, input sample_t value);
    sample_t b;
    int      waited;
    int      i;
    waited = 0;
    while (!sd_rd && waited < RD_TIMEOUT)
    begin
        @(negedge clock);
        waited++;
    end
    if (!sd_rd)
    begin
        $display("timeout: sd_rd was never raised for block %0d", bytes_supplied / 512);
        errors++;
        return;
    end
    for (i = 0; i < SD_BLOCK_BYTES; i++)
    begin
        b = fixed ? value : sample_t'($urandom_range(255));
        @(posedge clock);
        #DRIVE_DELAY;
        sd_data           = b;
        sd_read_available = 1'b1;
        history.push_back(b);
        bytes_supplied++;
        @(posedge clock);
        #DRIVE_DELAY;
        sd_read_available = 1'b0;
        // idle cycle before the next byte
        @(posedge clock);
    end
endtask

`endif

// ==== verification/audio_frame_tb.sv ====
module audio_frame_tb
    import storage_pkg::*;
    import sample_pkg::*;
();

    localparam int DRIVE_DELAY   = 10;
    localparam int RANDOM_BLOCKS = 5;
    // two constant blocks follow for the PWM checks
    localparam int TOTAL_BLOCKS  = RANDOM_BLOCKS + 2;
    localparam int WINDOW_COUNT  =
        (TOTAL_BLOCKS * SD_BLOCK_BYTES - WINDOW_LEN) / WINDOW_HOP + 1;
    localparam int RD_TIMEOUT    = 20000;
    localparam int FRAME_TIMEOUT = 40000;
    localparam int PWM_TIMEOUT   = 200000;
    localparam sample_t PWM_LEVEL_A = 8'h5a;
    localparam sample_t PWM_LEVEL_B = 8'hc3;

    logic        clock;
    logic        reset;
    sd_byte_t    sd_data;
    logic        sd_read_available;
    logic        sd_rd;
    sd_addr_t    sd_addr;
    logic        aud_pwm;
    logic        frame_valid;
    frame_beat_t frame;
    logic        frame_ready;

    // ring buffer write port inside the DUT for lining up the PWM window
    buf_write_t  observed_write;
    // every byte handed to the card side, in order
    sample_t     history[$];
    int          bytes_supplied = 0;
    int          errors = 0;
    int          beats_checked = 0;
    int          window_index = 0;
    int          beat_index = 0;
    sd_addr_t    last_sd_addr;
    // beat offered but not taken on the previous cycle
    logic        held = 1'b0;
    frame_beat_t held_beat;

    `include "audio_frame_model.svh"

    // reference beats of the window being checked
    window_t     expected;

    audio_frame_top #(
        .SAMPLE_DIVIDER (16),
        .FIFO_LOG_DEPTH (9)
    ) i_audio_frame_top (
        .clock             (clock),
        .reset             (reset),
        .sd_data           (sd_data),
        .sd_read_available (sd_read_available),
        .sd_rd             (sd_rd),
        .sd_addr           (sd_addr),
        .aud_pwm           (aud_pwm),
        .frame_valid       (frame_valid),
        .frame             (frame),
        .frame_ready       (frame_ready)
    );

    assign observed_write = i_audio_frame_top.sample_write;

    always #50 clock = ~clock;

    // first two windows at full rate, then ready is high 3 cycles out of 4
    always @(posedge clock)
    begin
        #DRIVE_DELAY;
        frame_ready = (window_index < 2) ? 1'b1 : ($urandom_range(3) != 0);
    end

    ////////////////////
    // PWM duty check

    task automatic check_pwm(input sample_t v);
        int run;
        int cycles;
        int high;
        run    = 0;
        cycles = 0;
        // four writes of v in a row mark the constant block
        while (run < 4 && cycles < PWM_TIMEOUT)
        begin
            @(negedge clock);
            cycles++;
            if (observed_write.strobe)
            begin
                run = (observed_write.data == v) ? run + 1 : 0;
            end
        end
        if (run < 4)
        begin
            $display("timeout: no run of samples 0x%h reached the ring buffer", v);
            errors++;
            return;
        end
        // level register and output register settle
        @(negedge clock);
        @(negedge clock);
        high = 0;
        repeat (256)
        begin
            @(negedge clock);
            if (aud_pwm)
            begin
                high++;
            end
            if (observed_write.strobe && observed_write.data != v)
            begin
                $display("sample changed away from 0x%h inside the PWM window", v);
                errors++;
            end
        end
        assert (high == int'(v))
        else
        begin
            $display("error aud_pwm high cycles: got 0x%h expected 0x%h", high, v);
            errors++;
        end
    endtask

    ////////////////////
    // monitors

    // sd_addr may only step by one block, right after a block ends
    always @(negedge clock)
    begin
        if (!reset && sd_addr != last_sd_addr)
        begin
            assert (sd_addr == last_sd_addr + sd_addr_t'(SD_BLOCK_BYTES))
            else
            begin
                $display("error sd_addr step: got 0x%h expected 0x%h", sd_addr,
                         last_sd_addr + sd_addr_t'(SD_BLOCK_BYTES));
                errors++;
            end
            assert (sd_addr == sd_addr_t'(bytes_supplied))
            else
            begin
                $display("error sd_addr: got 0x%h expected 0x%h", sd_addr, bytes_supplied);
                errors++;
            end
        end
        last_sd_addr = sd_addr;
    end

    // a stalled beat has to stay put
    always @(negedge clock)
    begin
        if (!reset && held)
        begin
            assert (frame_valid)
            else
            begin
                $display("frame_valid dropped before the beat was taken");
                errors++;
            end
            assert (frame == held_beat)
            else
            begin
                $display("error frame while stalled: got 0x%h expected 0x%h", frame, held_beat);
                errors++;
            end
        end
        held      = !reset && frame_valid && !frame_ready;
        held_beat = frame;
    end

    // compare every accepted beat with the reference window
    always @(negedge clock)
    begin
        if (!reset && frame_valid && frame_ready)
        begin
            if (beat_index == 0)
            begin
                assert (history.size() >= window_index * WINDOW_HOP + WINDOW_LEN)
                else
                begin
                    $display("window %0d started before its samples were supplied",
                             window_index);
                    errors++;
                end
                expected = expected_window(history, window_index);
            end
            assert (frame.data == expected[beat_index].data)
            else
            begin
                $display("error frame.data window %0d beat %0d: got 0x%h expected 0x%h",
                         window_index, beat_index, frame.data, expected[beat_index].data);
                errors++;
            end
            assert (frame.last == expected[beat_index].last)
            else
            begin
                $display("error frame.last window %0d beat %0d: got 0x%h expected 0x%h",
                         window_index, beat_index, frame.last, expected[beat_index].last);
                errors++;
            end
            beats_checked++;
            beat_index++;
            if (beat_index == WINDOW_LEN)
            begin
                beat_index = 0;
                window_index++;
            end
        end
    end

    ////////////////////
    // main sequence

    initial
    begin
        int block;
        int waited;
        void'($urandom(43));
        clock             = 1'b0;
        reset             = 1'b1;
        sd_data           = '0;
        sd_read_available = 1'b0;
        frame_ready       = 1'b1;
        repeat (3) @(posedge clock);
        #DRIVE_DELAY;
        assert (sd_addr == '0 && !sd_rd && !frame_valid && !aud_pwm)
        else
        begin
            $display("outputs not in their reset state at the end of reset");
            errors++;
        end
        reset = 1'b0;

        fork
            begin
                for (block = 0; block < TOTAL_BLOCKS; block++)
                begin
                    supply_block(block >= RANDOM_BLOCKS,
                                 (block == RANDOM_BLOCKS) ? PWM_LEVEL_A : PWM_LEVEL_B);
                end
            end
            begin
                check_pwm(PWM_LEVEL_A);
                check_pwm(PWM_LEVEL_B);
            end
        join

        // remaining samples drain from the FIFO, then the last window streams
        waited = 0;
        while (window_index < WINDOW_COUNT && waited < FRAME_TIMEOUT)
        begin
            @(negedge clock);
            waited++;
        end
        if (window_index < WINDOW_COUNT)
        begin
            $display("timeout: only %0d of %0d windows arrived", window_index, WINDOW_COUNT);
            errors++;
        end
        assert (sd_addr == sd_addr_t'(bytes_supplied))
        else
        begin
            $display("error sd_addr: got 0x%h expected 0x%h", sd_addr, bytes_supplied);
            errors++;
        end

        $display("windows %0d, beats checked %0d, errors %0d",
                 window_index, beats_checked, errors);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
